// File: logic/noc_pkg.sv
package noc_pkg;

    localparam int VC_NUM = 4;
    localparam int VC_SIZE = 2;
    localparam int BUFFER_DEPTH = 4;
    localparam int DATA_WIDTH = 16;
    localparam int CREDIT_WIDTH = $clog2(BUFFER_DEPTH + 1);

    typedef enum logic [1:0]
    {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL
    } flit_label_t;

    typedef enum logic [2:0]
    {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

    // head flits keep the destination port in data[2:0]
    typedef struct packed
    {
        flit_label_t flit_label;
        logic [VC_SIZE-1:0] vc_id;
        logic [DATA_WIDTH-1:0] data;
    } flit_t;

endpackage

// File: logic/circular_buffer.sv
`timescale 1ns/1ps

module circular_buffer
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = BUFFER_DEPTH
)(
    input  logic  clk,
    input  logic  rst,
    input  flit_t data_i,
    input  logic  write_i,
    input  logic  read_i,
    output flit_t data_o,
    output logic  is_full_o,
    output logic  is_empty_o
);

    localparam int PTR_WIDTH = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_WIDTH = $clog2(BUFFER_SIZE + 1);

    flit_t mem [BUFFER_SIZE];
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic write_en;
    logic read_en;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(BUFFER_SIZE - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign is_full_o = (count == CNT_WIDTH'(BUFFER_SIZE));
    assign is_empty_o = (count == '0);
    assign write_en = write_i && !is_full_o;
    assign read_en = read_i && !is_empty_o;
    assign data_o = mem[rd_ptr];   // oldest flit is always visible

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (write_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (read_en)
                rd_ptr <= next_ptr(rd_ptr);
            case ({write_en, read_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither leave occupancy as is
            endcase
        end
    end

endmodule

// File: logic/input_buffer.sv
`timescale 1ns/1ps

module input_buffer
    import noc_pkg::*;
#(
    parameter int BUFFER_SIZE = BUFFER_DEPTH
)(
    input  logic               clk,
    input  logic               rst,
    input  flit_t              data_i,
    input  logic               write_i,
    input  logic               read_i,
    input  logic               va_grant_i,
    input  logic [VC_SIZE-1:0] vc_new_i,
    output flit_t              data_o,
    output port_t              out_port_o,
    output logic               va_req_o,
    output logic               sa_req_o,
    output logic               is_full_o
);

    typedef enum logic [1:0]
    {
        IDLE,
        VA,
        SA
    } state_t;

    state_t state;
    flit_t front;
    logic is_empty;
    logic front_is_head;
    logic front_is_tail;
    logic [VC_SIZE-1:0] downstream_vc;

    circular_buffer #(
        .BUFFER_SIZE(BUFFER_SIZE)
    ) u_circular_buffer (
        .clk       (clk),
        .rst       (rst),
        .data_i    (data_i),
        .write_i   (write_i),
        .read_i    (read_i),
        .data_o    (front),
        .is_full_o (is_full_o),
        .is_empty_o(is_empty)
    );

    assign front_is_head = !is_empty && (front.flit_label == HEAD || front.flit_label == HEADTAIL);
    assign front_is_tail = (front.flit_label == TAIL) || (front.flit_label == HEADTAIL);
    assign va_req_o = (state == VA);
    assign sa_req_o = (state == SA) && !is_empty;

    always_comb
    begin
        data_o = front;
        data_o.vc_id = downstream_vc;   // rewritten to the channel won in VA
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (front_is_head)
                        state <= VA;
                VA:
                    if (va_grant_i)
                        state <= SA;
                SA:
                    if (read_i && front_is_tail)
                        state <= IDLE;   // packet fully forwarded
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && front_is_head)
            out_port_o <= port_t'(front.data[2:0]);
        if (state == VA && va_grant_i)
            downstream_vc <= vc_new_i;
    end

endmodule

// File: logic/vc_allocator.sv
`timescale 1ns/1ps

module vc_allocator
    import noc_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [VC_NUM-1:0]  va_req_i,
    output logic [VC_NUM-1:0]  va_grant_o,
    output logic [VC_SIZE-1:0] vc_new_o,
    input  logic               release_valid_i,
    input  logic [VC_SIZE-1:0] release_vc_i
);

    logic [VC_NUM-1:0] busy;
    logic [VC_SIZE-1:0] rr_ptr;
    logic [VC_SIZE-1:0] free_vc;
    logic free_found;
    logic [VC_SIZE-1:0] winner;
    logic winner_found;
    logic grant_valid;

    // lowest-numbered free downstream channel
    always_comb
    begin
        free_vc = '0;
        free_found = 1'b0;
        for (int i = VC_NUM - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_vc = VC_SIZE'(i);
                free_found = 1'b1;
            end
        end
    end

    always_comb
    begin
        logic [VC_SIZE-1:0] idx;
        winner = rr_ptr;
        winner_found = 1'b0;
        for (int i = VC_NUM - 1; i >= 0; i--)
        begin
            idx = rr_ptr + VC_SIZE'(i);   // walking down leaves the pointer's nearest requester
            if (va_req_i[idx])
            begin
                winner = idx;
                winner_found = 1'b1;
            end
        end
    end

    assign grant_valid = winner_found && free_found;
    assign va_grant_o = grant_valid ? (VC_NUM'(1) << winner) : '0;
    assign vc_new_o = free_vc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy   <= '0;
            rr_ptr <= '0;
        end
        else
        begin
            if (release_valid_i)
                busy[release_vc_i] <= 1'b0;
            if (grant_valid)
            begin
                busy[free_vc] <= 1'b1;
                rr_ptr <= winner + 1'b1;
            end
        end
    end

endmodule

// File: logic/switch_arbiter.sv
`timescale 1ns/1ps

module switch_arbiter
    import noc_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [VC_NUM-1:0]  sa_req_i,
    input  flit_t              flits_i [VC_NUM],
    input  port_t              ports_i [VC_NUM],
    input  logic               credit_valid_i,
    input  logic [VC_SIZE-1:0] credit_vc_i,
    output logic [VC_NUM-1:0]  read_o,
    output flit_t              flit_o,
    output logic               flit_valid_o,
    output port_t              out_port_o,
    output logic               release_valid_o,
    output logic [VC_SIZE-1:0] release_vc_o
);

    logic [CREDIT_WIDTH-1:0] credit_cnt [VC_NUM];
    logic [VC_NUM-1:0] eligible;
    logic [VC_SIZE-1:0] rr_ptr;
    logic [VC_SIZE-1:0] winner;
    logic send;
    flit_t send_flit;

    always_comb
    begin
        for (int i = 0; i < VC_NUM; i++)
            eligible[i] = sa_req_i[i] && (credit_cnt[flits_i[i].vc_id] != '0);
    end

    always_comb
    begin
        logic [VC_SIZE-1:0] idx;
        winner = rr_ptr;
        send = 1'b0;
        for (int i = VC_NUM - 1; i >= 0; i--)
        begin
            idx = rr_ptr + VC_SIZE'(i);
            if (eligible[idx])
            begin
                winner = idx;
                send = 1'b1;
            end
        end
    end

    assign send_flit = flits_i[winner];
    assign read_o = send ? (VC_NUM'(1) << winner) : '0;
    assign release_valid_o = send && (send_flit.flit_label == TAIL ||
                                      send_flit.flit_label == HEADTAIL);
    assign release_vc_o = send_flit.vc_id;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < VC_NUM; i++)
                credit_cnt[i] <= CREDIT_WIDTH'(BUFFER_DEPTH);
        end
        else
        begin
            for (int i = 0; i < VC_NUM; i++)
            begin
                case ({send && send_flit.vc_id == VC_SIZE'(i),
                       credit_valid_i && credit_vc_i == VC_SIZE'(i)})
                    2'b10:   credit_cnt[i] <= credit_cnt[i] - 1'b1;
                    2'b01:   credit_cnt[i] <= credit_cnt[i] + 1'b1;
                    default: credit_cnt[i] <= credit_cnt[i];
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flit_valid_o <= 1'b0;
            rr_ptr       <= '0;
        end
        else
        begin
            flit_valid_o <= send;
            if (send)
                rr_ptr <= winner + 1'b1;   // winner drops to lowest priority
        end
    end

    always_ff @(posedge clk)
    begin
        if (send)
        begin
            flit_o     <= send_flit;
            out_port_o <= ports_i[winner];
        end
    end

endmodule

// File: logic/router_input_unit.sv
`timescale 1ns/1ps

module router_input_unit
    import noc_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  flit_t              flit_i,
    input  logic               flit_valid_i,
    output logic               credit_valid_o,
    output logic [VC_SIZE-1:0] credit_vc_o,
    output flit_t              flit_o,
    output logic               flit_valid_o,
    output port_t              out_port_o,
    input  logic               credit_valid_i,
    input  logic [VC_SIZE-1:0] credit_vc_i
);

    flit_t buf_flit [VC_NUM];
    port_t buf_port [VC_NUM];
    logic [VC_NUM-1:0] buf_write;
    logic [VC_NUM-1:0] buf_full;
    logic [VC_NUM-1:0] va_req;
    logic [VC_NUM-1:0] va_grant;
    logic [VC_NUM-1:0] sa_req;
    logic [VC_NUM-1:0] buf_read;
    logic [VC_SIZE-1:0] vc_new;
    logic release_valid;
    logic [VC_SIZE-1:0] release_vc;

    for (genvar i = 0; i < VC_NUM; i++)
    begin : g_vc
        assign buf_write[i] = flit_valid_i && (flit_i.vc_id == VC_SIZE'(i)) && !buf_full[i];

        input_buffer #(
            .BUFFER_SIZE(BUFFER_DEPTH)
        ) u_input_buffer (
            .clk       (clk),
            .rst       (rst),
            .data_i    (flit_i),
            .write_i   (buf_write[i]),
            .read_i    (buf_read[i]),
            .va_grant_i(va_grant[i]),
            .vc_new_i  (vc_new),
            .data_o    (buf_flit[i]),
            .out_port_o(buf_port[i]),
            .va_req_o  (va_req[i]),
            .sa_req_o  (sa_req[i]),
            .is_full_o (buf_full[i])
        );
    end

    vc_allocator u_vc_allocator (
        .clk            (clk),
        .rst            (rst),
        .va_req_i       (va_req),
        .va_grant_o     (va_grant),
        .vc_new_o       (vc_new),
        .release_valid_i(release_valid),
        .release_vc_i   (release_vc)
    );

    switch_arbiter u_switch_arbiter (
        .clk            (clk),
        .rst            (rst),
        .sa_req_i       (sa_req),
        .flits_i        (buf_flit),
        .ports_i        (buf_port),
        .credit_valid_i (credit_valid_i),
        .credit_vc_i    (credit_vc_i),
        .read_o         (buf_read),
        .flit_o         (flit_o),
        .flit_valid_o   (flit_valid_o),
        .out_port_o     (out_port_o),
        .release_valid_o(release_valid),
        .release_vc_o   (release_vc)
    );

    // one upstream credit for the slot freed by this cycle's read
    assign credit_valid_o = |buf_read;

    always_comb
    begin
        credit_vc_o = '0;
        for (int i = 0; i < VC_NUM; i++)
        begin
            if (buf_read[i])
                credit_vc_o = VC_SIZE'(i);
        end
    end

endmodule

// File: verification/router_unit_sva.sv
`timescale 1ns/1ps

module router_unit_sva
    import noc_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               send_valid_i,
    input  flit_t              send_flit_i,
    input  logic               credit_in_valid_i,
    input  logic [VC_SIZE-1:0] credit_in_vc_i,
    input  logic               credit_out_valid_i,
    input  logic [VC_SIZE-1:0] credit_out_vc_i,
    input  logic [VC_NUM-1:0]  write_i,
    input  logic [VC_NUM-1:0]  grant_i,
    input  logic [VC_SIZE-1:0] grant_vc_i
);

    int credits [VC_NUM];    // shadow of the downstream credit counters
    int written [VC_NUM];
    int returned [VC_NUM];
    logic [VC_NUM-1:0] busy;    // owned from grant until its tail leaves on flit_o
    logic tail_out;
    int fail_count = 0;

    assign tail_out = send_valid_i && (send_flit_i.flit_label == TAIL ||
                                       send_flit_i.flit_label == HEADTAIL);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < VC_NUM; i++)
            begin
                credits[i]  <= BUFFER_DEPTH;
                written[i]  <= 0;
                returned[i] <= 0;
            end
            busy <= '0;
        end
        else
        begin
            for (int i = 0; i < VC_NUM; i++)
            begin
                credits[i] <= credits[i]
                    - int'(send_valid_i && send_flit_i.vc_id == VC_SIZE'(i))
                    + int'(credit_in_valid_i && credit_in_vc_i == VC_SIZE'(i));
                written[i] <= written[i] + int'(write_i[i]);
                returned[i] <= returned[i]
                    + int'(credit_out_valid_i && credit_out_vc_i == VC_SIZE'(i));
            end
            if (tail_out)
                busy[send_flit_i.vc_id] <= 1'b0;
            if (|grant_i)
                busy[grant_vc_i] <= 1'b1;
        end
    end

    // a departing flit was chosen while its channel still held a credit
    assert property (@(posedge clk) disable iff (rst)
        send_valid_i |-> credits[send_flit_i.vc_id] > 0)
    else
    begin
        fail_count++;
        $error("flit sent on a downstream channel without credit");
    end

    // the tail shows on flit_o one cycle after the allocator sees its release
    assert property (@(posedge clk) disable iff (rst)
        |grant_i |-> !busy[grant_vc_i] || (tail_out && send_flit_i.vc_id == grant_vc_i))
    else
    begin
        fail_count++;
        $error("downstream channel granted while still owned by a packet");
    end

    assert property (@(posedge clk) disable iff (rst)
        credit_out_valid_i |-> returned[credit_out_vc_i] < written[credit_out_vc_i])
    else
    begin
        fail_count++;
        $error("upstream credit returned without a matching flit");
    end

endmodule

bind router_input_unit router_unit_sva u_router_unit_sva (
    .clk               (clk),
    .rst               (rst),
    .send_valid_i      (flit_valid_o),
    .send_flit_i       (flit_o),
    .credit_in_valid_i (credit_valid_i),
    .credit_in_vc_i    (credit_vc_i),
    .credit_out_valid_i(credit_valid_o),
    .credit_out_vc_i   (credit_vc_o),
    .write_i           (buf_write),
    .grant_i           (va_grant),
    .grant_vc_i        (vc_new)
);

// File: verification/router_checker.sv
`timescale 1ns/1ps

module router_checker
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  flit_t                 up_flit_i,
    input  logic                  up_valid_i,
    input  logic                  up_credit_valid_i,
    input  logic [VC_SIZE-1:0]    up_credit_vc_i,
    input  flit_t                 down_flit_i,
    input  logic                  down_valid_i,
    input  port_t                 down_port_i,
    input  logic                  down_credit_valid_i,
    input  logic [VC_SIZE-1:0]    down_credit_vc_i,
    input  logic                  exp_valid_i,
    input  logic [DATA_WIDTH-1:0] exp_first_i,
    input  logic [3:0]            exp_len_i,
    input  port_t                 exp_port_i,
    input  logic                  end_check_i,
    output int                    error_count_o,
    output int                    packet_count_o
);

    int errors = 0;
    int packets = 0;
    logic [DATA_WIDTH-1:0] exp_first [$];
    int exp_len [$];
    port_t exp_port [$];
    bit exp_done [$];
    bit open_pkt [VC_NUM];      // per downstream channel
    int open_id [VC_NUM];
    int open_pos [VC_NUM];
    int up_sent [VC_NUM];
    int up_credits [VC_NUM];
    int outstanding [VC_NUM];
    bit first_sent;

    assign error_count_o = errors;
    assign packet_count_o = packets;

    task automatic mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    function automatic flit_label_t expected_label(input int pos, input int len);
        if (len == 1)
            return HEADTAIL;
        if (pos == 0)
            return HEAD;
        if (pos == len - 1)
            return TAIL;
        return BODY;
    endfunction

    function automatic int find_packet(input logic [DATA_WIDTH-1:0] first);
        for (int i = 0; i < exp_first.size(); i++)
        begin
            if (!exp_done[i] && exp_first[i] == first)
                return i;
        end
        return -1;
    endfunction

    task automatic check_departure();
        int d;
        int id;
        flit_label_t want;
        d = int'(down_flit_i.vc_id);
        outstanding[d]++;
        if (outstanding[d] > BUFFER_DEPTH)
            mismatch($sformatf("%0d flits outstanding on downstream vc %0d", outstanding[d], d));
        if (down_flit_i.flit_label == HEAD || down_flit_i.flit_label == HEADTAIL)
        begin
            if (open_pkt[d])
                mismatch($sformatf("head on downstream vc %0d while a packet is open", d));
            id = find_packet(down_flit_i.data);
            if (id < 0)
            begin
                mismatch($sformatf("head data %h matches no packet sent", down_flit_i.data));
                open_pkt[d] = 1'b0;
                return;
            end
            open_pkt[d] = 1'b1;
            open_id[d] = id;
            open_pos[d] = 0;
        end
        else if (!open_pkt[d])
        begin
            mismatch($sformatf("label %0d on downstream vc %0d outside a packet",
                               down_flit_i.flit_label, d));
            return;
        end
        id = open_id[d];
        want = expected_label(open_pos[d], exp_len[id]);
        if (down_flit_i.flit_label != want)
            mismatch($sformatf("vc %0d flit %0d label %0d, expected %0d",
                               d, open_pos[d], down_flit_i.flit_label, want));
        if (down_flit_i.data != exp_first[id] + DATA_WIDTH'(open_pos[d]))
            mismatch($sformatf("vc %0d flit %0d data %h, expected %h", d, open_pos[d],
                               down_flit_i.data, exp_first[id] + DATA_WIDTH'(open_pos[d])));
        if (down_port_i != exp_port[id])
            mismatch($sformatf("vc %0d out_port %0d, expected %0d", d, down_port_i, exp_port[id]));
        open_pos[d]++;
        if (open_pos[d] >= exp_len[id] || down_flit_i.flit_label == TAIL ||
            down_flit_i.flit_label == HEADTAIL)
        begin
            open_pkt[d] = 1'b0;
            exp_done[id] = 1'b1;
            packets++;
        end
    endtask

    task automatic check_end();
        for (int c = 0; c < VC_NUM; c++)
        begin
            if (up_credits[c] != up_sent[c])
                mismatch($sformatf("vc %0d returned %0d upstream credits for %0d flits",
                                   c, up_credits[c], up_sent[c]));
            if (open_pkt[c])
                mismatch($sformatf("downstream vc %0d still holds an open packet", c));
        end
        for (int i = 0; i < exp_first.size(); i++)
        begin
            if (!exp_done[i])
                mismatch($sformatf("packet starting with %h never completed", exp_first[i]));
        end
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (down_valid_i === 1'b1 || up_credit_valid_i === 1'b1)
                mismatch("valid output high during reset");
            first_sent = 1'b0;
            for (int c = 0; c < VC_NUM; c++)
            begin
                open_pkt[c] = 1'b0;
                up_sent[c] = 0;
                up_credits[c] = 0;
                outstanding[c] = 0;
            end
        end
        else
        begin
            if (!first_sent && (down_valid_i === 1'b1 || up_credit_valid_i === 1'b1))
                mismatch("valid output high before the first flit was sent");
            if (up_valid_i)
            begin
                first_sent = 1'b1;
                up_sent[up_flit_i.vc_id]++;
            end
            if (up_credit_valid_i)
                up_credits[up_credit_vc_i]++;
            if (exp_valid_i)
            begin
                exp_first.push_back(exp_first_i);
                exp_len.push_back(int'(exp_len_i));
                exp_port.push_back(exp_port_i);
                exp_done.push_back(1'b0);
            end
            if (down_credit_valid_i)
                outstanding[down_credit_vc_i]--;
            if (down_valid_i)
                check_departure();
            if (end_check_i)
                check_end();
        end
    end

endmodule

// File: verification/tb_router_input_unit.sv
`timescale 1ns/1ps

module tb_router_input_unit
    import noc_pkg::*;
();

    localparam int NUM_ROWS = 10;
    localparam int HOLD_CYCLES = 20;
    localparam int RANDOM_SEED = 18536;

    typedef struct packed
    {
        logic [VC_SIZE-1:0]    vc;
        logic [3:0]            len;
        port_t                 port;
        logic [DATA_WIDTH-1:0] first;
        logic                  throttle;
    } packet_row_t;

    // upstream vc, length, port, first data word (low bits = port), throttle
    localparam packet_row_t PACKETS [NUM_ROWS] = '{
        '{2'd0, 4'd1, LOCAL, 16'h0100, 1'b0},
        '{2'd1, 4'd4, NORTH, 16'h0201, 1'b0},
        '{2'd2, 4'd3, SOUTH, 16'h0302, 1'b0},
        '{2'd3, 4'd5, EAST,  16'h0403, 1'b0},
        '{2'd0, 4'd8, WEST,  16'h0504, 1'b1},
        '{2'd1, 4'd2, EAST,  16'h0603, 1'b0},
        '{2'd2, 4'd6, NORTH, 16'h0701, 1'b0},
        '{2'd3, 4'd1, LOCAL, 16'h0800, 1'b0},
        '{2'd1, 4'd3, SOUTH, 16'h0902, 1'b0},
        '{2'd0, 4'd4, WEST,  16'h0a04, 1'b0}
    };

    logic clk;
    logic rst;
    flit_t flit_i;
    logic flit_valid_i;
    logic credit_valid_o;
    logic [VC_SIZE-1:0] credit_vc_o;
    flit_t flit_o;
    logic flit_valid_o;
    port_t out_port_o;
    logic credit_valid_i;
    logic [VC_SIZE-1:0] credit_vc_i;
    logic exp_valid;
    logic [DATA_WIDTH-1:0] exp_first;
    logic [3:0] exp_len;
    port_t exp_port;
    logic end_check;
    int checker_errors;
    int packets_done;
    int cycle = 0;
    int hold_until = 0;
    int used_credits [VC_NUM] = '{default: 0};
    int returned_credits [VC_NUM] = '{default: 0};

    router_input_unit u_router_input_unit (
        .clk           (clk),
        .rst           (rst),
        .flit_i        (flit_i),
        .flit_valid_i  (flit_valid_i),
        .credit_valid_o(credit_valid_o),
        .credit_vc_o   (credit_vc_o),
        .flit_o        (flit_o),
        .flit_valid_o  (flit_valid_o),
        .out_port_o    (out_port_o),
        .credit_valid_i(credit_valid_i),
        .credit_vc_i   (credit_vc_i)
    );

    router_checker u_router_checker (
        .clk                (clk),
        .rst                (rst),
        .up_flit_i          (flit_i),
        .up_valid_i         (flit_valid_i),
        .up_credit_valid_i  (credit_valid_o),
        .up_credit_vc_i     (credit_vc_o),
        .down_flit_i        (flit_o),
        .down_valid_i       (flit_valid_o),
        .down_port_i        (out_port_o),
        .down_credit_valid_i(credit_valid_i),
        .down_credit_vc_i   (credit_vc_i),
        .exp_valid_i        (exp_valid),
        .exp_first_i        (exp_first),
        .exp_len_i          (exp_len),
        .exp_port_i         (exp_port),
        .end_check_i        (end_check),
        .error_count_o      (checker_errors),
        .packet_count_o     (packets_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    always @(posedge clk)
    begin
        if (!rst && credit_valid_o === 1'b1)
            returned_credits[credit_vc_o]++;
    end

    function automatic int credits_left(input int c);
        return BUFFER_DEPTH - used_credits[c] + returned_credits[c];
    endfunction

    function automatic int total_flits();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_ROWS; i++)
            sum += PACKETS[i].len;
        return sum;
    endfunction

    task automatic send_flit(input int r, input int p);
        flit_t f;
        if (PACKETS[r].len == 1)
            f.flit_label = HEADTAIL;
        else if (p == 0)
            f.flit_label = HEAD;
        else if (p == PACKETS[r].len - 1)
            f.flit_label = TAIL;
        else
            f.flit_label = BODY;
        f.vc_id = PACKETS[r].vc;
        f.data = PACKETS[r].first + DATA_WIDTH'(p);
        flit_i = f;
        flit_valid_i = 1'b1;
        used_credits[f.vc_id]++;
        if (p == 0)
        begin
            exp_valid = 1'b1;
            exp_first = PACKETS[r].first;
            exp_len = PACKETS[r].len;
            exp_port = PACKETS[r].port;
            if (PACKETS[r].throttle)
                hold_until = cycle + HOLD_CYCLES;
        end
    endtask

    // one packet open per upstream vc, flits picked round-robin among open ones
    task automatic run_rows(input int first_row, input int last_row);
        int next_row;
        int active [VC_NUM];
        int pos [VC_NUM];
        int rr;
        int c;
        bit sent;
        bit pending;
        next_row = first_row;
        rr = 0;
        pending = 1'b1;
        for (int v = 0; v < VC_NUM; v++)
        begin
            active[v] = -1;
            pos[v] = 0;
        end
        while (pending)
        begin
            while (next_row <= last_row && active[PACKETS[next_row].vc] < 0)
            begin
                active[PACKETS[next_row].vc] = next_row;
                pos[PACKETS[next_row].vc] = 0;
                next_row++;
            end
            sent = 1'b0;
            flit_valid_i = 1'b0;
            exp_valid = 1'b0;
            for (int k = 0; k < VC_NUM; k++)
            begin
                c = (rr + k) % VC_NUM;
                if (!sent && active[c] >= 0 && credits_left(c) > 0)
                begin
                    send_flit(active[c], pos[c]);
                    pos[c]++;
                    if (pos[c] == PACKETS[active[c]].len)
                        active[c] = -1;
                    rr = (c + 1) % VC_NUM;
                    sent = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            pending = (next_row <= last_row);
            for (int v = 0; v < VC_NUM; v++)
            begin
                if (active[v] >= 0)
                    pending = 1'b1;
            end
        end
        flit_valid_i = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic wait_packets(input int n);
        while (packets_done < n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = u_router_input_unit.u_router_unit_sva.fail_count;
        $display("Errors: %0d checker, %0d assertion; packets received %0d of %0d",
                 checker_errors, assert_errors, packets_done, NUM_ROWS);
        if (checker_errors == 0 && assert_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    // downstream receiver frees one slot per flit after a short random delay
    initial
    begin : downstream_model
        int due [$];
        logic [VC_SIZE-1:0] vcs [$];
        credit_valid_i = 1'b0;
        credit_vc_i = '0;
        void'($urandom(RANDOM_SEED));
        forever
        begin
            @(posedge clk);
            #1;
            if (flit_valid_o === 1'b1)
            begin
                vcs.push_back(flit_o.vc_id);
                due.push_back(cycle + int'($urandom_range(3, 0)));
            end
            credit_valid_i = 1'b0;
            if (due.size() > 0 && cycle >= due[0] && cycle >= hold_until)
            begin
                credit_valid_i = 1'b1;
                credit_vc_i = vcs.pop_front();
                void'(due.pop_front());
            end
        end
    end

    initial
    begin
        rst = 1'b1;
        flit_i = '0;
        flit_valid_i = 1'b0;
        exp_valid = 1'b0;
        exp_first = '0;
        exp_len = '0;
        exp_port = LOCAL;
        end_check = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        run_rows(0, 0);   // a lone packet first
        wait_packets(1);
        run_rows(1, NUM_ROWS - 1);
        wait_packets(NUM_ROWS);
        repeat (4) @(posedge clk);
        #1;
        end_check = 1'b1;
        @(posedge clk);
        #1;
        end_check = 1'b0;
        @(posedge clk);
        #1;
        finish_run();
    end

    initial
    begin : watchdog
        int limit;
        limit = 40 * total_flits() + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: all.f
logic/noc_pkg.sv
logic/circular_buffer.sv
logic/input_buffer.sv
logic/vc_allocator.sv
logic/switch_arbiter.sv
logic/router_input_unit.sv
verification/router_unit_sva.sv
verification/router_checker.sv
verification/tb_router_input_unit.sv
